// File: sources.f
+incdir+testbench
src/aluPkg.sv
src/shifter.sv
src/alu.sv
src/instrDecoder.sv
src/issueBuffer.sv
src/executeUnit.sv
src/aluExecute.sv
testbench/aluExecuteTb.sv

// File: testbench/aluTbModel.svh
`ifndef ALU_TB_MODEL_SVH
`define ALU_TB_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference ALU, straight from RV32I semantics
//////////////////////////////////////////////////////////////////////

function automatic logic [31:0] refResult(input logic [31:0] ins, a, b);
  logic [31:0]        immI, immS, opB;
  logic signed [31:0] sra;
  logic [4:0]         sh;
  logic               alt;                  // Bit 30 selects sub and sra
  immI = {{20{ins[31]}}, ins[31:20]};
  immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  alt  = ins[30];
  opB  = (ins[6:0] == opOp) ? b : immI;
  sh   = opB[4:0];                          // Low 5 bits only
  sra  = $signed(a) >>> sh;
  if (ins[6:0] == opLoad) return a + immI;  // Address, funct3 ignored
  if (ins[6:0] == opStore) return a + immS;
  case (ins[14:12])
    f3Add:   return (alt && ins[6:0] == opOp) ? a - opB : a + opB;
    f3Sll:   return a << sh;
    f3Slt:   return {31'b0, $signed(a) < $signed(opB)};
    f3Sltu:  return {31'b0, a < opB};
    f3Xor:   return a ^ opB;
    f3Sr:    return alt ? sra : a >> sh;
    f3Or:    return a | opB;
    default: return a & opB;
  endcase
endfunction

// S-type has no rd field, so stores report x0
function automatic regIdxT refRd(input logic [31:0] ins);
  return (ins[6:0] == opStore) ? regIdxT'(0) : ins[11:7];
endfunction

// Instruction builders
function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                      input logic [2:0] f3, input logic [4:0] rdIdx);
  return {f7, rs2, rs1, f3, rdIdx, opOp};
endfunction

function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rdIdx,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rdIdx, opc};
endfunction

function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs1, rs2,
                                      input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
endfunction

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// File: testbench/aluExecuteTb.sv
`timescale 1ns/1ps

module aluExecuteTb import aluPkg::*; ();

  `include "aluTbModel.svh"

  localparam int numRandom = 240;
  localparam int numIssued = numRandom + 11;          // Plus directed ones
  localparam int timeoutNs = (numIssued * 40 + 8) * 8;  // 40 cycles each, plus reset

  logic        clk, rstN, instrValid, hold;
  logic [31:0] instr, rs1Val, rs2Val;
  logic        resultValid, illegal, bufferFull;
  logic [31:0] result;
  regIdxT      rd;

  logic [31:0] stimState, holdState;  // LFSR states
  logic [36:0] expQ [$];              // {rd, result} in issue order
  int          illegalPending;        // Illegal strobes still owed
  logic        holdOn, sawFull;

  aluExecute #(.BUFFER_DEPTH(4)) u_aluExecute (
    .clk, .rstN, .instrValid, .instr, .rs1Val, .rs2Val, .hold,
    .resultValid, .result, .rd, .illegal, .bufferFull
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Takes n bits, one LFSR step per bit
  task automatic takeBits(input int n, inout logic [31:0] st, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      st = lfsrNext(st);
      v  = {v[30:0], st[0]};
    end
  endtask

  task automatic reportError(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "Mismatch");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // One-cycle strobe, expected entry pushed as it goes out
  task automatic drive(input logic [31:0] ins, a, b);
    @(posedge clk);
    instrValid <= 1'b1;
    instr      <= ins;
    rs1Val     <= a;
    rs2Val     <= b;
    case (ins[6:0])
      opOp, opOpImm, opLoad, opStore: expQ.push_back({refRd(ins), refResult(ins, a, b)});
      default: illegalPending++;
    endcase
    @(posedge clk);
    instrValid <= 1'b0;
  endtask

  task automatic issue(input logic [31:0] ins, a, b);
    @(negedge clk);
    while (bufferFull) @(negedge clk);  // Back-pressure
    drive(ins, a, b);
    @(posedge clk);  // Gap so bufferFull is current at the next check
  endtask

  task automatic waitIdle();
    while (expQ.size() != 0 || illegalPending != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  // resultValid three cycles after instrValid when idle
  task automatic checkLatency(input logic [31:0] ins, a, b);
    int lat;
    waitIdle();
    drive(ins, a, b);
    lat = 1;
    @(negedge clk);
    while (!resultValid && lat < 10) begin
      @(negedge clk);
      lat++;
    end
    assert (lat == 3)
      else reportError($sformatf("resultValid %0d cycles after instrValid, not 3", lat));
  endtask

  task automatic issueRandom();
    logic [31:0] a, b, r, ins;
    logic [11:0] imm;
    logic [6:0]  f7;
    logic [2:0]  f3;
    takeBits(32, stimState, a);
    takeBits(32, stimState, b);
    takeBits(32, stimState, r);
    f3  = r[14:12];
    f7  = ((f3 == f3Add || f3 == f3Sr) && r[30]) ? 7'h20 : 7'h00;  // sub, sra
    imm = (f3 == f3Sll || f3 == f3Sr) ? {f7, r[24:20]} : r[31:20];  // Legal shamt form
    if (r[5:3] == 3'd0) b = a;  // Equal operands now and then
    case (r[2:0])
      3'd0, 3'd1, 3'd2: ins = rType(f7, r[24:20], r[19:15], f3, r[11:7]);
      3'd3, 3'd4:       ins = iType(imm, r[19:15], f3, r[11:7], opOpImm);
      3'd5:             ins = iType(r[31:20], r[19:15], f3, r[11:7], opLoad);
      3'd6:             ins = sType(r[31:20], r[19:15], r[24:20], f3);
      default:          ins = {r[31:7], 7'b1110111};  // Unsupported opcode
    endcase
    issue(ins, a, b);
  endtask

  // Random hold bursts, toggles with odds of one in eight
  initial begin
    logic [31:0] r;
    forever begin
      @(posedge clk);
      if (!holdOn) begin
        hold <= 1'b0;
      end else begin
        takeBits(3, holdState, r);
        if (r[2:0] == 3'd0) hold <= ~hold;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare against the expected queue
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    logic [36:0] exp;
    if (bufferFull) sawFull = 1'b1;
    if (resultValid) begin
      assert (expQ.size() != 0) else reportError("result with nothing expected");
      exp = expQ.pop_front();
      assert (result === exp[31:0] && rd === exp[36:32])
        else reportError($sformatf("rd %0d result %h, expected rd %0d result %h",
                                   rd, result, exp[36:32], exp[31:0]));
    end
    if (illegal) begin
      assert (illegalPending > 0) else reportError("illegal strobe not expected");
      illegalPending--;
    end
  end

  initial begin
    #(timeoutNs);
    $display("Watchdog expired after %0d ns with results still outstanding", timeoutNs);
    $display("Simulation failed");
    $fatal(1, "Timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rstN           = 1'b0;
    instrValid     = 1'b0;
    instr          = '0;
    rs1Val         = '0;
    rs2Val         = '0;
    hold           = 1'b0;
    holdOn         = 1'b0;
    sawFull        = 1'b0;
    illegalPending = 0;
    stimState      = 32'haa76_5efd;
    holdState      = 32'haa76_5efd;
    repeat (8) @(posedge clk);
    rstN <= 1'b1;

    checkLatency(rType(7'h00, 5'd2, 5'd1, f3Add, 5'd3), 32'h7fff_ffff, 32'h1);
    issue(rType(7'h00, 5'd2, 5'd1, f3Slt, 5'd4), 32'hffff_ffff, 32'h1);   // Mixed signs
    issue(rType(7'h00, 5'd2, 5'd1, f3Sltu, 5'd5), 32'hffff_ffff, 32'h1);
    issue(rType(7'h00, 5'd2, 5'd1, f3Slt, 5'd6), 32'h8000_0000, 32'h8000_0000);
    issue(iType(12'hfff, 5'd1, f3Sltu, 5'd7, opOpImm), 32'h5, 32'h0);     // Imm is all ones
    issue(iType(12'hfff, 5'd1, f3Slt, 5'd8, opOpImm), 32'h0, 32'h0);
    issue(iType(12'h41f, 5'd1, f3Sr, 5'd9, opOpImm), 32'h8000_0000, 32'h0);  // srai 31
    issue(rType(7'h20, 5'd2, 5'd1, f3Sr, 5'd10), 32'h8000_00f0, 32'hffff_ffe4);
    issue(iType(12'h801, 5'd1, 3'd6, 5'd11, opLoad), 32'h0000_4000, 32'h0);
    issue(sType(12'h800, 5'd1, 5'd2, 3'd7), 32'h0000_1000, 32'h0);
    issue({25'h0, 7'h7f}, 32'h0, 32'h0);  // Illegal, no result
    waitIdle();

    holdOn = 1'b1;
    repeat (numRandom) issueRandom();
    @(negedge clk);
    holdOn = 1'b0;
    waitIdle();

    if (sawFull && expQ.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("End check: %0d results still expected, bufferFull seen high %0b",
               expQ.size(), sawFull);
      $display("Simulation failed");
      $fatal(1, "End check");
    end
  end

endmodule

// File: src/aluExecute.sv
`timescale 1ns/1ps

module aluExecute import aluPkg::*; #(
  parameter int BUFFER_DEPTH = 4
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            instrValid,
  input  logic [31:0]     instr,
  input  logic [XLEN-1:0] rs1Val,
  input  logic [XLEN-1:0] rs2Val,
  input  logic            hold,
  output logic            resultValid,
  output logic [XLEN-1:0] result,
  output regIdxT          rd,
  output logic            illegal,
  output logic            bufferFull
);

  // Decoder to buffer
  logic            decValid;
  aluCtrlT         decCtrl;
  logic [2:0]      decFunct3;
  logic [6:0]      decFunct7;
  logic [XLEN-1:0] decA, decB;
  regIdxT          decRd;

  // Buffer to execute
  logic            bufEmpty, bufPop;
  aluCtrlT         bufCtrl;
  logic [2:0]      bufFunct3;
  logic [6:0]      bufFunct7;
  logic [XLEN-1:0] bufA, bufB;
  regIdxT          bufRd;

  instrDecoder u_instrDecoder (
    .clk, .rstN, .instrValid, .instr, .rs1Val, .rs2Val, .bufferFull,
    .decValid, .decCtrl, .decFunct3, .decFunct7, .decA, .decB, .decRd, .illegal
  );

  issueBuffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_issueBuffer (
    .clk, .rstN, .decValid, .decCtrl, .decFunct3, .decFunct7, .decA, .decB, .decRd,
    .bufPop, .bufEmpty, .bufferFull,
    .bufCtrl, .bufFunct3, .bufFunct7, .bufA, .bufB, .bufRd
  );

  executeUnit u_executeUnit (
    .clk, .rstN, .hold, .bufEmpty,
    .bufCtrl, .bufFunct3, .bufFunct7, .bufA, .bufB, .bufRd,
    .bufPop, .resultValid, .result, .rd
  );

endmodule

// File: src/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import aluPkg::*; (
  input  logic            clk,
  input  logic            rstN,
  input  logic            hold,         // Back-end stall level
  input  logic            bufEmpty,
  input  aluCtrlT         bufCtrl,
  input  logic [2:0]      bufFunct3,
  input  logic [6:0]      bufFunct7,
  input  logic [XLEN-1:0] bufA,
  input  logic [XLEN-1:0] bufB,
  input  regIdxT          bufRd,
  output logic            bufPop,       // Take head this cycle
  output logic            resultValid,
  output logic [XLEN-1:0] result,
  output regIdxT          rd
);

  logic [XLEN-1:0] aluResult;

  assign bufPop = ~bufEmpty & ~hold;  // Combinational pop

  alu u_alu (
    .A          (bufA),
    .B          (bufB),
    .aluControl (bufCtrl),
    .funct3     (bufFunct3),
    .funct7     (bufFunct7),
    .result     (aluResult),
    .sum        ()            // Address path not needed here
  );

  //////////////////////////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) resultValid <= 1'b0;
    else       resultValid <= bufPop;  // One cycle after pop
  end

  always_ff @(posedge clk) begin
    if (bufPop) begin
      result <= aluResult;
      rd     <= bufRd;
    end
  end

  // A strobed result comes from a real buffer entry
  assert property (@(posedge clk) disable iff (!rstN)
                   resultValid |-> !$isunknown({result, rd}))
    else $error("resultValid with unknown result or rd");

endmodule

// File: src/issueBuffer.sv
`timescale 1ns/1ps

module issueBuffer import aluPkg::*; #(
  parameter int BUFFER_DEPTH = 4
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            decValid,    // Write strobe
  input  aluCtrlT         decCtrl,
  input  logic [2:0]      decFunct3,
  input  logic [6:0]      decFunct7,
  input  logic [XLEN-1:0] decA,
  input  logic [XLEN-1:0] decB,
  input  regIdxT          decRd,
  input  logic            bufPop,      // Read strobe from execute
  output logic            bufEmpty,
  output logic            bufferFull,  // Full or one short of it
  output aluCtrlT         bufCtrl,
  output logic [2:0]      bufFunct3,
  output logic [6:0]      bufFunct7,
  output logic [XLEN-1:0] bufA,
  output logic [XLEN-1:0] bufB,
  output regIdxT          bufRd
);

  localparam int ptrW   = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
  localparam int cntW   = $clog2(BUFFER_DEPTH + 1);
  localparam int entryW = $bits(aluCtrlT) + 3 + 7 + 2 * XLEN + $bits(regIdxT);

  logic [entryW-1:0] mem [BUFFER_DEPTH];  // Entry storage
  logic [entryW-1:0] wrEntry;
  logic [ptrW-1:0]   wrPtr, rdPtr;
  logic [cntW-1:0]   count;               // Occupancy

  // Wrap at depth, works for any depth
  function automatic logic [ptrW-1:0] ptrInc(input logic [ptrW-1:0] p);
    return (p == ptrW'(BUFFER_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  assign wrEntry = {decCtrl, decFunct3, decFunct7, decA, decB, decRd};

  always_ff @(posedge clk) begin
    if (decValid) mem[wrPtr] <= wrEntry;
  end

  // Head shown combinationally
  assign {bufCtrl, bufFunct3, bufFunct7, bufA, bufB, bufRd} = mem[rdPtr];

  //////////////////////////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (decValid) wrPtr <= ptrInc(wrPtr);
      if (bufPop)   rdPtr <= ptrInc(rdPtr);
      case ({decValid, bufPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  assign bufEmpty   = (count == '0);
  assign bufferFull = (count >= cntW'(BUFFER_DEPTH - 1));  // Slack for decoder stage

  // Consumer pops only real entries
  assert property (@(posedge clk) disable iff (!rstN) bufPop |-> !bufEmpty)
    else $error("issueBuffer underflow");

  // Producer never writes into a full buffer
  assert property (@(posedge clk) disable iff (!rstN)
                   decValid |-> (count < cntW'(BUFFER_DEPTH)))
    else $error("issueBuffer overflow");

endmodule

// File: src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import aluPkg::*; (
  input  logic            clk,
  input  logic            rstN,
  input  logic            instrValid,   // One-cycle strobe
  input  logic [31:0]     instr,
  input  logic [XLEN-1:0] rs1Val,
  input  logic [XLEN-1:0] rs2Val,
  input  logic            bufferFull,   // Checked against instrValid only
  output logic            decValid,     // Buffer write strobe
  output aluCtrlT         decCtrl,
  output logic [2:0]      decFunct3,
  output logic [6:0]      decFunct7,
  output logic [XLEN-1:0] decA,
  output logic [XLEN-1:0] decB,
  output regIdxT          decRd,
  output logic            illegal       // Unsupported opcode strobe
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] immI, immS;  // Sign-extended immediates
  logic [XLEN-1:0] nextB;
  logic            isOp, isOpImm, isStore, isMem;
  logic            isCmp;       // slt family needs a subtract
  logic            legal;
  aluCtrlT         nextCtrl;
  regIdxT          nextRd;

  //////////////////////////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////////////////////////

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign immI   = {{(XLEN-12){instr[31]}}, instr[31:20]};
  assign immS   = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

  assign isOp    = (opcode == opOp);
  assign isOpImm = (opcode == opOpImm);
  assign isStore = (opcode == opStore);
  assign isMem   = (opcode == opLoad) | isStore;
  assign legal   = isOp | isOpImm | isMem;
  assign isCmp   = (funct3 == f3Slt) | (funct3 == f3Sltu);

  // Controls
  always_comb begin
    nextCtrl.aluOp    = isOp | isOpImm;                           // Loads/stores just add
    nextCtrl.subArith = (isOp & (funct7[5] | isCmp)) |            // sub, sra, slt, sltu
                        (isOpImm & (isCmp | ((funct3 == f3Sr) & funct7[5])));  // srai, slti
  end

  // Operand B select
  always_comb begin
    if (isOp)         nextB = rs2Val;
    else if (isStore) nextB = immS;
    else              nextB = immI;   // OP-IMM and loads
  end

  assign nextRd = isStore ? regIdxT'(0) : instr[11:7];  // Stores write no register

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      decValid <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      decValid <= instrValid & legal;
      illegal  <= instrValid & ~legal;  // Pulse, nothing written
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin
      decCtrl   <= nextCtrl;
      decFunct3 <= funct3;
      decFunct7 <= funct7;
      decA      <= rs1Val;
      decB      <= nextB;
      decRd     <= nextRd;
    end
  end

  // Source must respect the buffer's back-pressure level
  assert property (@(posedge clk) disable iff (!rstN) instrValid |-> !bufferFull)
    else $error("instrValid strobed while bufferFull high");

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu import aluPkg::*; (
  input  logic [XLEN-1:0] A,           // rs1 or base address
  input  logic [XLEN-1:0] B,           // rs2 or immediate
  input  aluCtrlT         aluControl,  // subArith, aluOp
  input  logic [2:0]      funct3,
  input  logic [6:0]      funct7,
  output logic [XLEN-1:0] result,
  output logic [XLEN-1:0] sum          // Raw adder output
);

  logic [XLEN-1:0] condInvB;    // B or ~B
  logic [XLEN-1:0] shiftY;
  logic [XLEN-1:0] sltRes, sltuRes;
  logic            carry, neg;  // Adder flags
  logic            aSign, bSign;
  logic            lt, ltu;

  //////////////////////////////////////////////////////////////////////
  // Adder
  //////////////////////////////////////////////////////////////////////

  assign condInvB = aluControl.subArith ? ~B : B;

  // Two's complement subtract when subArith set
  assign {carry, sum} = A + condInvB + {{(XLEN-1){1'b0}}, aluControl.subArith};

  //////////////////////////////////////////////////////////////////////
  // Compare flags from A - B
  //////////////////////////////////////////////////////////////////////

  assign neg   = sum[XLEN-1];
  assign aSign = A[XLEN-1];
  assign bSign = B[XLEN-1];

  // Signs differ means no overflow doubt, A negative wins
  assign lt  = (aSign ^ bSign) ? aSign : neg;
  assign ltu = ~carry;  // Borrow out

  assign sltRes  = {{(XLEN-1){1'b0}}, lt};
  assign sltuRes = {{(XLEN-1){1'b0}}, ltu};

  // Shifts
  shifter u_shifter (
    .A     (A),
    .Amt   (B[4:0]),     // Low five bits only
    .Right (funct3[2]),  // sr vs sll
    .Arith (funct7[5]),  // sra/srai encoding bit
    .Y     (shiftY)
  );

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (!aluControl.aluOp) begin
      result = sum;  // Load/store address
    end else begin
      case (funct3)
        f3Add:  result = sum;      // add, sub, addi
        f3Sll:  result = shiftY;
        f3Slt:  result = sltRes;
        f3Sltu: result = sltuRes;
        f3Xor:  result = A ^ B;
        f3Sr:   result = shiftY;   // srl, sra
        f3Or:   result = A | B;
        f3And:  result = A & B;
      endcase
    end
  end

endmodule

// File: src/shifter.sv
`timescale 1ns/1ps

module shifter import aluPkg::*; (
  input  logic [XLEN-1:0] A,      // Value to shift
  input  logic [4:0]      Amt,    // Shift amount
  input  logic            Right,  // 1 right, 0 left
  input  logic            Arith,  // Sign fill on right shifts
  output logic [XLEN-1:0] Y
);

  logic            fill;             // Bit shifted in from the top
  logic [XLEN-1:0] revA, revOut;
  logic [XLEN-1:0] stg [0:5];        // Log stages, stg[0] is input

  assign fill = Right & Arith & A[XLEN-1];

  // Left shift done as a right shift of the bit-reversed word
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      revA[i] = A[XLEN-1-i];
    end
  end

  assign stg[0] = Right ? A : revA;

  // Stage s moves by 2**s
  for (genvar s = 0; s < 5; s++) begin : gStage
    assign stg[s+1] = Amt[s] ? {{(2**s){fill}}, stg[s][XLEN-1:2**s]} : stg[s];
  end

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      revOut[i] = stg[5][XLEN-1-i];  // Undo reversal
    end
  end

  assign Y = Right ? stg[5] : revOut;

endmodule

// File: src/aluPkg.sv
package aluPkg;

  //////////////////////////////////////////////////////////////////////
  // Data width
  //////////////////////////////////////////////////////////////////////

  localparam int XLEN = 32;  // RV32 only

  // Major opcodes accepted by the decoder
  localparam logic [6:0] opOp    = 7'b0110011;  // R-type ALU
  localparam logic [6:0] opOpImm = 7'b0010011;  // I-type ALU
  localparam logic [6:0] opLoad  = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;

  // ALU control bundle
  typedef struct packed {
    logic subArith;  // Invert B and add one, or arithmetic shift
    logic aluOp;     // 0 means address add, 1 means funct3 select
  } aluCtrlT;

  // funct3 operation codes
  localparam logic [2:0] f3Add  = 3'b000;  // add, sub, addi
  localparam logic [2:0] f3Sll  = 3'b001;
  localparam logic [2:0] f3Slt  = 3'b010;
  localparam logic [2:0] f3Sltu = 3'b011;
  localparam logic [2:0] f3Xor  = 3'b100;
  localparam logic [2:0] f3Sr   = 3'b101;  // srl or sra by funct7
  localparam logic [2:0] f3Or   = 3'b110;
  localparam logic [2:0] f3And  = 3'b111;

  typedef logic [4:0] regIdxT;  // x0 to x31

endpackage
